// File: source/execPkg.sv
/*
	Execute stage package
	Widths, vector types, operation classes, ALU opcodes and the
	bit positions of the extended opcode shared across the stage.
*/
package execPkg;

	localparam int DataWidth = 64;
	localparam int LaneWidth = 32;
	localparam int ChunkWidth = 16;

	typedef logic [DataWidth-1:0] dataWord;
	typedef logic [LaneWidth-1:0] laneWord;
	typedef logic [7:0] extOpcode;
	typedef logic [3:0] aluOpcode;
	// bit 1 is S, bit 0 is T
	typedef logic [1:0] statusBits;
	typedef logic [6:0] countValue;
	typedef logic [1:0] opClass;

	localparam opClass ClassAlu = 2'd0;
	localparam opClass ClassUnary = 2'd1;

	// low nibble of the extended opcode
	localparam aluOpcode OpAdd = 4'h0;
	localparam aluOpcode OpSub = 4'h1;
	localparam aluOpcode OpAdc = 4'h2;
	localparam aluOpcode OpSbb = 4'h3;
	localparam aluOpcode OpTst = 4'h4;
	localparam aluOpcode OpAnd = 4'h5;
	localparam aluOpcode OpOr = 4'h6;
	localparam aluOpcode OpXor = 4'h7;
	localparam aluOpcode OpCmpNe = 4'h8;
	localparam aluOpcode OpCmpHs = 4'h9;
	localparam aluOpcode OpCmpGe = 4'hA;
	localparam aluOpcode OpNor = 4'hB;
	localparam aluOpcode OpCmpEq = 4'hC;
	localparam aluOpcode OpCmpHi = 4'hD;
	localparam aluOpcode OpCmpGt = 4'hE;
	localparam aluOpcode OpCselT = 4'hF;

	// quad selects 64-bit, zero-ext picks ZX over SX; both set means packed lanes
	localparam int QuadBit = 5;
	localparam int ZeroExtBit = 4;

endpackage

// File: source/carrySelectAdder.sv
/*
	Carry-select adder
	64-bit add or subtract built from 16-bit chunks, giving results for
	carry-in 0 and 1 at both the 32-bit and the 64-bit point.
*/
`timescale 1ns/1ps

module carrySelectAdder import execPkg::*; (
	input  dataWord            a,
	input  dataWord            b,
	input  logic               subtract,
	output logic [LaneWidth:0] sum32Carry0,
	output logic [LaneWidth:0] sum32Carry1,
	output logic [DataWidth:0] sum64Carry0,
	output logic [DataWidth:0] sum64Carry1
);

	localparam int ChunkCount = DataWidth / ChunkWidth;

	dataWord bInput;
	logic [ChunkWidth:0] chunkSum0 [ChunkCount];
	logic [ChunkWidth:0] chunkSum1 [ChunkCount];
	logic [LaneWidth:0] high32Carry0;
	logic [LaneWidth:0] high32Carry1;

	// subtract is a + ~b + 1, so carry-in 1 gives the plain difference
	assign bInput = subtract ? ~b : b;

	// each chunk precomputes both carry-in versions
	always_comb begin
		for (int i = 0; i < ChunkCount; i++) begin
			chunkSum0[i] = {1'b0, a[i*ChunkWidth +: ChunkWidth]}
				+ {1'b0, bInput[i*ChunkWidth +: ChunkWidth]};
			chunkSum1[i] = {1'b0, a[i*ChunkWidth +: ChunkWidth]}
				+ {1'b0, bInput[i*ChunkWidth +: ChunkWidth]} + 17'd1;
		end
	end

	// low half, chunk 0 carry picks chunk 1
	assign sum32Carry0 = {chunkSum0[0][ChunkWidth] ? chunkSum1[1] : chunkSum0[1],
		chunkSum0[0][ChunkWidth-1:0]};
	assign sum32Carry1 = {chunkSum1[0][ChunkWidth] ? chunkSum1[1] : chunkSum0[1],
		chunkSum1[0][ChunkWidth-1:0]};

	// high half, same arrangement
	assign high32Carry0 = {chunkSum0[2][ChunkWidth] ? chunkSum1[3] : chunkSum0[3],
		chunkSum0[2][ChunkWidth-1:0]};
	assign high32Carry1 = {chunkSum1[2][ChunkWidth] ? chunkSum1[3] : chunkSum0[3],
		chunkSum1[2][ChunkWidth-1:0]};

	// low half carry out selects the high half
	assign sum64Carry0 = {sum32Carry0[LaneWidth] ? high32Carry1 : high32Carry0,
		sum32Carry0[LaneWidth-1:0]};
	assign sum64Carry1 = {sum32Carry1[LaneWidth] ? high32Carry1 : high32Carry0,
		sum32Carry1[LaneWidth-1:0]};

endmodule

// File: source/compareFlags.sv
/*
	Compare flags
	Zero, carry, sign and overflow for the low lane, the quad and the
	high lane, and the outcome of the selected compare or test for each.
*/
`timescale 1ns/1ps

module compareFlags import execPkg::*; (
	input  dataWord            rs,
	input  dataWord            rt,
	input  logic [LaneWidth:0] diff32,
	input  logic [DataWidth:0] diff64,
	input  logic [LaneWidth:0] diffHigh,
	input  aluOpcode           op,
	output logic               lowFlag,
	output logic               quadFlag,
	output logic               highFlag
);

	// V set when operand signs differ and the result sign differs from rs
	function automatic logic overflow(input logic rsSign, input logic rtSign,
		input logic resultSign);
		return (rsSign ^ rtSign) & (resultSign ^ rsSign);
	endfunction

	function automatic logic condition(input aluOpcode code, input logic zero,
		input logic carry, input logic sign, input logic over, input logic tstZero);
		logic outcome;
		case (code)
			OpTst:   outcome = tstZero;
			OpCmpNe: outcome = !zero;
			OpCmpEq: outcome = zero;
			OpCmpHs: outcome = carry;
			OpCmpHi: outcome = carry && !zero;
			OpCmpGe: outcome = (sign == over);
			OpCmpGt: outcome = (sign == over) && !zero;
			default: outcome = 1'b0;
		endcase
		return outcome;
	endfunction

	logic lowZero;
	logic highZero;
	logic lowTstZero;
	logic highTstZero;

	assign lowZero = (diff32[LaneWidth-1:0] == '0);
	assign highZero = (diffHigh[LaneWidth-1:0] == '0);
	assign lowTstZero = ((rs[LaneWidth-1:0] & rt[LaneWidth-1:0]) == '0);
	assign highTstZero = ((rs[DataWidth-1:LaneWidth] & rt[DataWidth-1:LaneWidth]) == '0);

	assign lowFlag = condition(op, lowZero, diff32[LaneWidth], diff32[LaneWidth-1],
		overflow(rs[LaneWidth-1], rt[LaneWidth-1], diff32[LaneWidth-1]), lowTstZero);

	// quad zero is the same subtraction as the two lanes but with the carry chained
	assign quadFlag = condition(op, diff64[DataWidth-1:0] == '0, diff64[DataWidth],
		diff64[DataWidth-1], overflow(rs[DataWidth-1], rt[DataWidth-1], diff64[DataWidth-1]),
		lowTstZero && highTstZero);

	assign highFlag = condition(op, highZero, diffHigh[LaneWidth], diffHigh[LaneWidth-1],
		overflow(rs[DataWidth-1], rt[DataWidth-1], diffHigh[LaneWidth-1]), highTstZero);

endmodule

// File: source/leadingZeroCount.sv
/*
	Leading-zero count
	Counts zeros from bit 63, or from bit 31 for a 32-bit operand.
*/
`timescale 1ns/1ps

module leadingZeroCount import execPkg::*; (
	input  dataWord   value,
	input  logic      quad,
	output countValue count
);

	localparam int GroupCount = DataWidth / ChunkWidth;

	function automatic logic [3:0] groupLeadingZeros(input logic [ChunkWidth-1:0] group);
		logic [3:0] zeros;
		zeros = 4'd0;
		// highest set bit wins
		for (int i = 0; i < ChunkWidth; i++) begin
			if (group[i]) begin
				zeros = 4'(ChunkWidth - 1 - i);
			end
		end
		return zeros;
	endfunction

	dataWord searchWord;

	// ones below a 32-bit operand stop the search at 32
	assign searchWord = quad ? value : {value[LaneWidth-1:0], {LaneWidth{1'b1}}};

	always_comb begin
		count = countValue'(DataWidth);
		for (int g = 0; g < GroupCount; g++) begin
			if (searchWord[g*ChunkWidth +: ChunkWidth] != '0) begin
				count = countValue'((GroupCount - 1 - g) * ChunkWidth)
					+ countValue'(groupLeadingZeros(searchWord[g*ChunkWidth +: ChunkWidth]));
			end
		end
	end

endmodule

// File: source/execAlu.sv
/*
	Execute ALU
	Single-cycle integer ALU over 32-bit, 64-bit and packed 32-bit lanes,
	producing the next T and S bits and a registered result.
*/
`timescale 1ns/1ps

module execAlu import execPkg::*; (
	input  logic      clock,
	input  dataWord   rs,
	input  dataWord   rt,
	input  extOpcode  extOp,
	input  opClass    opKind,
	input  logic      hold,
	input  statusBits srIn,
	output dataWord   result,
	output statusBits srNext
);

	// high lane of a packed op, carry kept apart from the low lane
	function automatic logic [LaneWidth:0] laneSum(input laneWord x, input laneWord y,
		input logic carryIn);
		return {1'b0, x} + {1'b0, y} + {{LaneWidth{1'b0}}, carryIn};
	endfunction

	aluOpcode op;
	logic isQuad;
	logic zeroExt;
	logic isPacked;
	logic srT;
	logic srS;

	logic [LaneWidth:0] add32Carry0;
	logic [LaneWidth:0] add32Carry1;
	logic [DataWidth:0] add64Carry0;
	logic [DataWidth:0] add64Carry1;
	logic [LaneWidth:0] sub32Carry0;
	logic [LaneWidth:0] sub32Carry1;
	logic [DataWidth:0] sub64Carry0;
	logic [DataWidth:0] sub64Carry1;

	laneWord rsHigh;
	laneWord rtHigh;
	logic [LaneWidth:0] highAdd0;
	logic [LaneWidth:0] highAdd1;
	logic [LaneWidth:0] highSub0;
	logic [LaneWidth:0] highSub1;

	logic lowFlag;
	logic quadFlag;
	logic highFlag;
	countValue clzCount;
	dataWord logicValue;

	logic [LaneWidth:0] lowValue;
	logic [DataWidth:0] quadValue;
	logic [LaneWidth:0] highValue;
	logic lowT;
	logic quadT;
	logic highS;
	dataWord aluValue;
	logic nextT;
	logic nextS;

	assign op = extOp[3:0];
	assign isQuad = extOp[QuadBit];
	assign zeroExt = extOp[ZeroExtBit];
	assign isPacked = isQuad && zeroExt;
	assign srT = srIn[0];
	assign srS = srIn[1];

	carrySelectAdder addUnit (
		.a(rs), .b(rt), .subtract(1'b0),
		.sum32Carry0(add32Carry0), .sum32Carry1(add32Carry1),
		.sum64Carry0(add64Carry0), .sum64Carry1(add64Carry1)
	);

	carrySelectAdder subUnit (
		.a(rs), .b(rt), .subtract(1'b1),
		.sum32Carry0(sub32Carry0), .sum32Carry1(sub32Carry1),
		.sum64Carry0(sub64Carry0), .sum64Carry1(sub64Carry1)
	);

	assign rsHigh = rs[DataWidth-1:LaneWidth];
	assign rtHigh = rt[DataWidth-1:LaneWidth];
	assign highAdd0 = laneSum(rsHigh, rtHigh, 1'b0);
	assign highAdd1 = laneSum(rsHigh, rtHigh, 1'b1);
	assign highSub0 = laneSum(rsHigh, ~rtHigh, 1'b0);
	assign highSub1 = laneSum(rsHigh, ~rtHigh, 1'b1);

	compareFlags compare (
		.rs(rs), .rt(rt),
		.diff32(sub32Carry1), .diff64(sub64Carry1), .diffHigh(highSub1),
		.op(op),
		.lowFlag(lowFlag), .quadFlag(quadFlag), .highFlag(highFlag)
	);

	leadingZeroCount clz (
		.value(rs), .quad(isQuad), .count(clzCount)
	);

	always_comb begin
		case (op)
			OpAnd:   logicValue = rs & rt;
			OpOr:    logicValue = rs | rt;
			OpXor:   logicValue = rs ^ rt;
			default: logicValue = ~(rs | rt);
		endcase
	end

	// compares and tests leave the value at zero
	always_comb begin
		lowValue = '0;
		quadValue = '0;
		highValue = '0;
		lowT = srT;
		quadT = srT;
		highS = srS;
		if (opKind == ClassUnary) begin
			if (op == OpAdd) begin
				lowValue = {26'd0, clzCount};
				quadValue = {58'd0, clzCount};
			end
		end else if (opKind == ClassAlu) begin
			case (op)
				OpAdd: begin
					lowValue = add32Carry0;
					quadValue = add64Carry0;
					highValue = highAdd0;
				end
				OpSub: begin
					lowValue = sub32Carry1;
					quadValue = sub64Carry1;
					highValue = highSub1;
				end
				OpAdc: begin
					lowValue = srT ? add32Carry1 : add32Carry0;
					quadValue = srT ? add64Carry1 : add64Carry0;
					highValue = srS ? highAdd1 : highAdd0;
					lowT = lowValue[LaneWidth];
					quadT = quadValue[DataWidth];
					highS = highValue[LaneWidth];
				end
				OpSbb: begin
					// borrow in drops the +1
					lowValue = srT ? sub32Carry0 : sub32Carry1;
					quadValue = srT ? sub64Carry0 : sub64Carry1;
					highValue = srS ? highSub0 : highSub1;
					lowT = !lowValue[LaneWidth];
					quadT = !quadValue[DataWidth];
					highS = !highValue[LaneWidth];
				end
				OpAnd, OpOr, OpXor, OpNor: begin
					lowValue = {1'b0, logicValue[LaneWidth-1:0]};
					quadValue = {1'b0, logicValue};
					highValue = {1'b0, logicValue[DataWidth-1:LaneWidth]};
				end
				OpCselT: begin
					lowValue = {1'b0, srT ? rs[LaneWidth-1:0] : rt[LaneWidth-1:0]};
					quadValue = {1'b0, srT ? rs : rt};
					highValue = {1'b0, srS ? rsHigh : rtHigh};
				end
				default: begin
					lowT = lowFlag;
					quadT = quadFlag;
					highS = highFlag;
				end
			endcase
		end
	end

	// shape by width mode; S only moves in packed mode
	always_comb begin
		if (isPacked) begin
			aluValue = {highValue[LaneWidth-1:0], lowValue[LaneWidth-1:0]};
			nextT = lowT;
			nextS = highS;
		end else if (isQuad) begin
			aluValue = quadValue[DataWidth-1:0];
			nextT = quadT;
			nextS = srS;
		end else begin
			aluValue = {zeroExt ? {LaneWidth{1'b0}} : {LaneWidth{lowValue[LaneWidth-1]}},
				lowValue[LaneWidth-1:0]};
			nextT = lowT;
			nextS = srS;
		end
	end

	assign srNext = {nextS, nextT};

	always_ff @(posedge clock) begin
		if (!hold) begin
			result <= aluValue;
		end
	end

endmodule

// File: source/statusFlags.sv
/*
	Status flags
	T and S register, loaded by an explicit write or an ALU commit,
	plus the valid bit of the result register.
*/
`timescale 1ns/1ps

module statusFlags import execPkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      commit,
	input  statusBits srNext,
	input  logic      srWrite,
	input  statusBits srWriteValue,
	input  logic      opValid,
	input  logic      hold,
	output statusBits sr,
	output logic      resultValid
);

	always_ff @(posedge clock) begin
		if (rst) begin
			sr <= '0;
			resultValid <= 1'b0;
		end else if (!hold) begin
			resultValid <= opValid;
			// explicit write beats the ALU
			if (srWrite) begin
				sr <= srWriteValue;
			end else if (commit) begin
				sr <= srNext;
			end
		end
	end

endmodule

// File: source/execStage.sv
/*
	Execute stage
	ALU and status register, one cycle from accepted operation to result.
*/
`timescale 1ns/1ps

module execStage import execPkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      opValid,
	input  opClass    opKind,
	input  extOpcode  extOp,
	input  dataWord   rs,
	input  dataWord   rt,
	input  logic      hold,
	input  logic      srWrite,
	input  statusBits srWriteValue,
	output dataWord   result,
	output logic      resultValid,
	output statusBits sr
);

	statusBits srNext;
	logic commit;

	assign commit = opValid && !hold;

	execAlu alu (
		.clock(clock), .rs(rs), .rt(rt), .extOp(extOp), .opKind(opKind),
		.hold(hold), .srIn(sr), .result(result), .srNext(srNext)
	);

	statusFlags flags (
		.clock(clock), .rst(rst), .commit(commit), .srNext(srNext),
		.srWrite(srWrite), .srWriteValue(srWriteValue), .opValid(opValid),
		.hold(hold), .sr(sr), .resultValid(resultValid)
	);

endmodule

// File: test/execChecker.sv
/*
	Execute stage checker
	Watches the result port and compares each fresh result and the status
	bits with the expected values queued by the testbench.
*/
`timescale 1ns/1ps

module execChecker import execPkg::*; (
	input logic      clock,
	input logic      rst,
	input logic      hold,
	input dataWord   result,
	input logic      resultValid,
	input statusBits sr
);

	int expectedIndex [$];
	dataWord expectedResult [$];
	statusBits expectedSr [$];
	int pending = 0;
	int checkCount = 0;
	int errorCount = 0;
	logic wasReset = 1'b0;
	// result register took a new value at the previous edge
	logic updated = 1'b0;

	task automatic addExpected(input int index, input dataWord value, input statusBits flags);
		expectedIndex.push_back(index);
		expectedResult.push_back(value);
		expectedSr.push_back(flags);
		pending++;
	endtask

	task automatic checkReset();
		checkCount++;
		if (resultValid !== 1'b0 || sr !== 2'b00) begin
			errorCount++;
			$display("ERROR at %0t: after reset resultValid=%b sr=%b, expected 0 and 00",
				$time, resultValid, sr);
		end else begin
			$display("test reset: resultValid low and sr 00");
		end
	endtask

	task automatic checkResult();
		int index;
		dataWord value;
		statusBits flags;
		if (expectedResult.size() == 0) begin
			errorCount++;
			$display("a result arrived at %0t with no operation waiting for it", $time);
		end else begin
			index = expectedIndex.pop_front();
			value = expectedResult.pop_front();
			flags = expectedSr.pop_front();
			pending--;
			checkCount++;
			if (result !== value || sr !== flags) begin
				errorCount++;
				$display("ERROR at %0t: test %0d result %h sr %b, expected %h sr %b",
					$time, index, result, sr, value, flags);
			end else begin
				$display("test %0d: result %h sr %b", index, result, sr);
			end
		end
	endtask

	task automatic reportCounts();
		$display("checks run %0d, errors %0d, results missing %0d",
			checkCount, errorCount, pending);
	endtask

	// outputs sampled at the edge still hold the previous edge's update
	always @(posedge clock) begin
		if (!rst && wasReset) begin
			checkReset();
		end
		if (!rst && updated && resultValid) begin
			checkResult();
		end
		wasReset = rst;
		updated = !hold;
	end

endmodule

// File: test/execStageTb.sv
/*
	Execute stage testbench
	Reads operations and expected values from the test file, drives them
	with random hold bubbles and leaves the comparing to the checker.
*/
`timescale 1ns/1ps

module execStageTb import execPkg::*; ();

	// preload flag, preload sr, opKind, extOp, rs, rt, result, sr
	localparam int RecordWidth = 216;
	localparam int MaxTests = 64;

	logic clock;
	logic rst;
	logic opValid;
	opClass opKind;
	extOpcode extOp;
	dataWord rs;
	dataWord rt;
	logic hold;
	logic srWrite;
	statusBits srWriteValue;
	dataWord result;
	logic resultValid;
	statusBits sr;

	logic [RecordWidth-1:0] testMem [MaxTests];
	int testTotal;
	int cycleLimit;
	int cycleCount;
	logic [15:0] lfsrState;

	execStage dut_i (
		.clock(clock), .rst(rst), .opValid(opValid), .opKind(opKind), .extOp(extOp),
		.rs(rs), .rt(rt), .hold(hold), .srWrite(srWrite), .srWriteValue(srWriteValue),
		.result(result), .resultValid(resultValid), .sr(sr)
	);

	execChecker execChecker (
		.clock(clock), .rst(rst), .hold(hold),
		.result(result), .resultValid(resultValid), .sr(sr)
	);

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] galoisStep(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 16'hB400;
		end
		return next;
	endfunction

	task automatic drawBit(output logic value);
		value = lfsrState[0];
		lfsrState = galoisStep(lfsrState);
	endtask

	task automatic applyOperation(input logic [RecordWidth-1:0] record);
		opValid = 1'b1;
		opKind = opClass'(record[207:204]);
		extOp = record[203:196];
		rs = record[195:132];
		rt = record[131:68];
		srWrite = 1'b0;
	endtask

	// optional sr preload, optional bubble, then the accepted cycle
	task automatic runTest(input int index);
		logic [RecordWidth-1:0] record;
		logic bubble;
		record = testMem[index];
		if (record[215:212] != 4'h0) begin
			@(posedge clock);
			#1;
			opValid = 1'b0;
			hold = 1'b0;
			srWrite = 1'b1;
			srWriteValue = statusBits'(record[211:208]);
		end
		drawBit(bubble);
		// chained carry ops always get a bubble so T has to survive a hold
		if (record[215:212] == 4'h0 && record[207:204] == 4'(ClassAlu)
			&& (record[199:196] == OpAdc || record[199:196] == OpSbb)) begin
			bubble = 1'b1;
		end
		if (bubble) begin
			@(posedge clock);
			#1;
			applyOperation(record);
			hold = 1'b1;
		end
		@(posedge clock);
		#1;
		applyOperation(record);
		hold = 1'b0;
		execChecker.addExpected(index, record[67:4], statusBits'(record[3:0]));
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		cycleCount = 0;
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: %0d results still missing after %0d cycles",
			execChecker.pending, cycleCount);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		opValid = 1'b0;
		opKind = ClassAlu;
		extOp = '0;
		rs = '0;
		rt = '0;
		hold = 1'b0;
		srWrite = 1'b0;
		srWriteValue = '0;
		lfsrState = 16'd37;
		testTotal = 0;
		$readmemh("test/execStageTests.txt", testMem);
		// an F in the top nibble ends the list
		while (testTotal < MaxTests && testMem[testTotal][215:212] != 4'hF) begin
			testTotal++;
		end
		if (testTotal == 0) begin
			$display("no tests could be read from test/execStageTests.txt");
		end
		cycleLimit = testTotal * 4 + 20;
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		for (int i = 0; i < testTotal; i++) begin
			runTest(i);
		end
		@(posedge clock);
		#1;
		opValid = 1'b0;
		hold = 1'b0;
		while (execChecker.pending != 0) begin
			@(negedge clock);
		end
		execChecker.reportCounts();
		if (testTotal > 0 && execChecker.errorCount == 0
			&& execChecker.checkCount == testTotal + 1) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: test/execStageTests.txt
// preload flag _ preload sr _ opKind _ extOp _ rs _ rt _ expected result _ expected sr
// sr is {S,T}; extOp bit 5 quad, bit 4 zero-extend, both set packed; F line ends
0_0_0_20_0123456789ABCDEF_1111111111111111_123456789ABCDF00_0
0_0_0_21_0000000000000005_0000000000000007_FFFFFFFFFFFFFFFE_0
0_0_0_00_000000007FFFFFFF_0000000000000001_FFFFFFFF80000000_0
0_0_0_10_123456787FFFFFFF_ABCDEF0000000001_0000000080000000_0
0_0_0_30_FFFFFFFF00000001_00000001FFFFFFFF_0000000000000000_0
1_2_0_22_FFFFFFFFFFFFFFFF_0000000000000002_0000000000000001_3
0_0_0_22_0000000000000010_0000000000000020_0000000000000031_2
1_0_0_23_0000000000000000_0000000000000001_FFFFFFFFFFFFFFFF_1
0_0_0_23_0000000000000005_0000000000000002_0000000000000002_0
0_0_0_0E_AAAAAAAA7FFFFFFF_55555555FFFFFFFF_0000000000000000_1
0_0_0_29_0000000000000001_FFFFFFFFFFFFFFFF_0000000000000000_0
0_0_0_2A_7FFFFFFFFFFFFFFF_8000000000000000_0000000000000000_1
0_0_0_3D_FFFFFFFF00000003_0000000100000003_0000000000000000_2
0_0_0_3C_1234567900000007_1234567800000007_0000000000000000_1
0_0_0_18_0000000000000009_FFFFFFFF00000009_0000000000000000_0
0_0_0_24_F0F0F0F0F0F0F0F0_0F0F0F0F0F0F0F0F_0000000000000000_1
0_0_0_3E_0000000180000000_8000000000000001_0000000000000000_2
0_0_0_25_FF00FF00FF00FF00_0FF00FF00FF00FF0_0F000F000F000F00_2
0_0_0_06_00000000F0000000_000000000000000F_FFFFFFFFF000000F_2
0_0_0_27_AAAAAAAAAAAAAAAA_FFFFFFFF00000000_55555555AAAAAAAA_2
0_0_0_2B_F0F0F0F0F0F0F0F0_0F0F0F0F0F0F0F00_000000000000000F_2
1_1_0_2F_1111111111111111_2222222222222222_1111111111111111_1
1_2_0_2F_1111111111111111_2222222222222222_2222222222222222_2
0_0_1_20_0000000000000000_0000000000000000_0000000000000040_2
0_0_1_00_FFFFFFFF00000000_0000000000000000_0000000000000020_2
0_0_1_20_0000010000000000_0000000000000000_0000000000000017_2
0_0_1_00_0000000000400000_0000000000000000_0000000000000009_2
F_0_0_00_0000000000000000_0000000000000000_0000000000000000_0

// File: filelist.f
source/execPkg.sv
source/carrySelectAdder.sv
source/compareFlags.sv
source/leadingZeroCount.sv
source/execAlu.sv
source/statusFlags.sv
source/execStage.sv
test/execChecker.sv
test/execStageTb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - source/execPkg.sv
  - source/carrySelectAdder.sv
  - source/compareFlags.sv
  - source/leadingZeroCount.sv
  - source/execAlu.sv
  - source/statusFlags.sv
  - source/execStage.sv
  - target: test
    files:
      - test/execChecker.sv
      - test/execStageTb.sv
